// ==== mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// ------------------------------
// data path widths
// ------------------------------

`define LEN_WORD 32          // data word.
`define LEN_MEM_ADDR 32      // byte address.

// ------------------------------
// data RAM geometry
// ------------------------------

// word index into the RAM, 1024 words.
`define LEN_MEMDATA_ADDR 10

`endif

// ==== mem_pkg.sv ====
`include "mem_defines.svh"

package mem_pkg;

    // load/store operations, bit 3 marks a store.
    typedef enum logic [3:0] {
        op_lb  = 4'b0000,
        op_lh  = 4'b0001,
        op_lw  = 4'b0010,
        op_lbu = 4'b0100,
        op_lhu = 4'b0101,
        op_sb  = 4'b1000,
        op_sh  = 4'b1001,
        op_sw  = 4'b1010
    } mem_op_e;

    typedef enum logic [1:0] {
        sz_byte = 2'd0,
        sz_half = 2'd1,
        sz_word = 2'd2
    } mem_size_e;

    // one-hot sequencer states.
    typedef enum logic [3:0] {
        st_idle  = 4'b0001,
        st_issue = 4'b0010,
        st_wait  = 4'b0100,
        st_done  = 4'b1000
    } access_state_e;

    typedef struct packed {
        mem_op_e                 op;
        logic [`LEN_MEM_ADDR-1:0] addr;
        logic [`LEN_WORD-1:0]     wdata;   // store data in low bits.
    } mem_req_t;

    typedef struct packed {
        logic                         is_write;
        logic [3:0]                   be;
        logic [`LEN_MEMDATA_ADDR-1:0] word_addr;
        logic [`LEN_WORD-1:0]         wdata_lanes;
    } ram_cmd_t;

    function automatic logic op_is_store(mem_op_e op);
        return (op == op_sb) || (op == op_sh) || (op == op_sw);
    endfunction

    function automatic mem_size_e op_size(mem_op_e op);
        case (op)
            op_lb, op_lbu, op_sb: return sz_byte;
            op_lh, op_lhu, op_sh: return sz_half;
            default: return sz_word;
        endcase
    endfunction

endpackage

// ==== lsu_align.sv ====
`timescale 1ns/10ps
`include "mem_defines.svh"

`default_nettype none

module lsu_align (
    input  wire logic                 clk,
    input  wire logic                 rstn,
    input  wire mem_pkg::mem_req_t    req,
    input  wire logic                 accepted,
    input  wire logic [`LEN_WORD-1:0] mem_rdata,
    output mem_pkg::ram_cmd_t         cmd,
    output logic [`LEN_WORD-1:0]      load_data
);
    import mem_pkg::*;

    mem_op_e     ld_op;     // operation of the access in flight.
    logic [1:0]  ld_lane;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    // ------------------------------
    // store side
    // ------------------------------

    always_comb begin
        cmd.is_write  = op_is_store(req.op);
        cmd.word_addr = req.addr[`LEN_MEMDATA_ADDR+1:2];
        case (op_size(req.op))
            sz_byte: begin
                cmd.be          = 4'b0001 << req.addr[1:0];
                cmd.wdata_lanes = {4{req.wdata[7:0]}};   // byte in every lane.
            end
            sz_half: begin
                // addr[0] ignored.
                cmd.be          = req.addr[1] ? 4'b1100 : 4'b0011;
                cmd.wdata_lanes = {2{req.wdata[15:0]}};
            end
            default: begin
                cmd.be          = 4'b1111;
                cmd.wdata_lanes = req.wdata;
            end
        endcase
    end

    // ------------------------------
    // load side
    // ------------------------------

    // req is still held while accepted is high.
    always_ff @(posedge clk) begin
        if (!rstn) begin
            ld_op   <= op_sw;          // reads back as zero until a load.
            ld_lane <= 2'b00;
        end else if (accepted) begin
            ld_op   <= req.op;
            ld_lane <= req.addr[1:0];
        end
    end

    assign sel_byte = mem_rdata[{ld_lane, 3'b000} +: 8];
    assign sel_half = ld_lane[1] ? mem_rdata[31:16] : mem_rdata[15:0];

    // ram output holds after the read, so this holds too.
    always_comb begin
        case (ld_op)
            op_lb: begin
                load_data = {{(`LEN_WORD-8){sel_byte[7]}}, sel_byte};
            end
            op_lbu: begin
                load_data = {{(`LEN_WORD-8){1'b0}}, sel_byte};
            end
            op_lh: begin
                load_data = {{(`LEN_WORD-16){sel_half[15]}}, sel_half};
            end
            op_lhu: begin
                load_data = {{(`LEN_WORD-16){1'b0}}, sel_half};
            end
            op_lw: begin
                load_data = mem_rdata;
            end
            default: begin
                load_data = '0;           // stores.
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== mem_access.sv ====
`timescale 1ns/10ps
`include "mem_defines.svh"

`default_nettype none

module mem_access (
    input  wire logic                         clk,
    input  wire logic                         rstn,
    input  wire logic                         order,
    input  wire mem_pkg::ram_cmd_t            cmd,
    output logic                              accepted,
    output logic                              accessed,
    output logic [`LEN_MEMDATA_ADDR-1:0]      mem_addr,
    output logic [`LEN_WORD-1:0]              mem_wdata,
    output logic [3:0]                        mem_we,
    output logic                              mem_re
);
    import mem_pkg::*;

    access_state_e state;
    ram_cmd_t      cmd_q;

    // ------------------------------
    // command latch
    // ------------------------------

    always_ff @(posedge clk) begin
        if (state == st_idle && order) begin
            cmd_q <= cmd;
        end
    end

    assign mem_addr  = cmd_q.word_addr;
    assign mem_wdata = cmd_q.wdata_lanes;

    // ------------------------------
    // sequencer
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!rstn) begin
            accepted <= 1'b0;
            accessed <= 1'b0;
            mem_we   <= 4'b0000;
            mem_re   <= 1'b0;
            state    <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    accessed <= 1'b0;
                    mem_we   <= 4'b0000;
                    if (order) begin
                        accepted <= 1'b1;
                        mem_re   <= 1'b1;      // read starts with the accept.
                        state    <= st_issue;
                    end else begin
                        accepted <= 1'b0;
                        mem_re   <= 1'b0;
                        state    <= st_idle;
                    end
                end
                st_issue: begin
                    accepted <= 1'b0;
                    accessed <= 1'b0;
                    // lanes only on a store.
                    mem_we   <= cmd_q.be & {4{cmd_q.is_write}};
                    mem_re   <= 1'b1;
                    state    <= st_wait;
                end
                st_wait: begin
                    accepted <= 1'b0;
                    accessed <= 1'b0;
                    mem_we   <= 4'b0000;
                    mem_re   <= 1'b0;
                    state    <= st_done;
                end
                st_done: begin
                    accepted <= 1'b0;
                    accessed <= 1'b1;          // ram data settled by now.
                    mem_we   <= 4'b0000;
                    mem_re   <= 1'b0;
                    state    <= st_idle;
                end
                default: begin
                    // lost one-hot, back to idle.
                    accepted <= 1'b0;
                    accessed <= 1'b0;
                    mem_we   <= 4'b0000;
                    mem_re   <= 1'b0;
                    state    <= st_idle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== data_ram.sv ====
`timescale 1ns/10ps
`include "mem_defines.svh"

`default_nettype none

module data_ram #(
    parameter int ADDR_BITS = `LEN_MEMDATA_ADDR
) (
    input  wire logic                 clk,
    input  wire logic [ADDR_BITS-1:0] addr,
    input  wire logic [`LEN_WORD-1:0] wdata,
    input  wire logic [3:0]           we,
    input  wire logic                 re,
    output logic [`LEN_WORD-1:0]      rdata
);

    localparam int DEPTH = 1 << ADDR_BITS;

    logic [`LEN_WORD-1:0] mem [0:DEPTH-1];

    // ------------------------------
    // byte lane writes
    // ------------------------------

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (we[i]) begin
                mem[addr][8*i +: 8] <= wdata[8*i +: 8];
            end
        end
    end

    // read-first, rdata holds while re is low.
    always_ff @(posedge clk) begin
        if (re) begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// ==== mem_top.sv ====
`timescale 1ns/10ps
`include "mem_defines.svh"

`default_nettype none

module mem_top (
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire mem_pkg::mem_req_t req,
    input  wire logic             order,
    output logic                  accepted,
    output logic                  accessed,
    output logic [`LEN_WORD-1:0]  load_data
);
    import mem_pkg::*;

    ram_cmd_t                     cmd;
    logic [`LEN_MEMDATA_ADDR-1:0] mem_addr;
    logic [`LEN_WORD-1:0]         mem_wdata;
    logic [`LEN_WORD-1:0]         mem_rdata;
    logic [3:0]                   mem_we;
    logic                         mem_re;

    lsu_align align_i (
        .clk       (clk),
        .rstn      (rstn),
        .req       (req),
        .accepted  (accepted),
        .mem_rdata (mem_rdata),
        .cmd       (cmd),
        .load_data (load_data)
    );

    mem_access access_i (
        .clk       (clk),
        .rstn      (rstn),
        .order     (order),
        .cmd       (cmd),
        .accepted  (accepted),
        .accessed  (accessed),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we),
        .mem_re    (mem_re)
    );

    data_ram #(
        .ADDR_BITS (`LEN_MEMDATA_ADDR)
    ) ram_i (
        .clk   (clk),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .we    (mem_we),
        .re    (mem_re),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;     // 10 ns period.
        end
    end

    // 8 rising edges in reset, released on a falling edge.
    initial begin
        rstn = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

// ==== mem_properties.sv ====
`timescale 1ns/10ps

module mem_properties (
    input logic                   clk,
    input logic                   rstn,
    input logic                   order,
    input logic                   accepted,
    input logic                   accessed,
    input logic [3:0]             mem_we,
    input mem_pkg::access_state_e state
);
    import mem_pkg::*;

    int fail_count = 0;     // read by the testbench.

    // ------------------------------
    // handshake pulses
    // ------------------------------

    a_accept_follows: assert property (@(posedge clk) disable iff (!rstn)
        (state == st_idle && order) |=> accepted)
        else begin
            $error("no accepted after an order in idle");
            fail_count++;
        end

    a_accept_cause: assert property (@(posedge clk) disable iff (!rstn)
        accepted |-> $past(state == st_idle && order))
        else begin
            $error("accepted without an order in idle");
            fail_count++;
        end

    a_access_latency: assert property (@(posedge clk) disable iff (!rstn)
        accepted |=> !accessed ##1 !accessed ##1 accessed)
        else begin
            $error("accessed not 3 cycles after accepted");
            fail_count++;
        end

    a_access_cause: assert property (@(posedge clk) disable iff (!rstn)
        accessed |-> $past(accepted, 3))
        else begin
            $error("accessed without accepted 3 cycles before");
            fail_count++;
        end

    // ------------------------------
    // strobes
    // ------------------------------

    a_we_window: assert property (@(posedge clk) disable iff (!rstn)
        (mem_we != 4'b0000) |-> $past(accepted))
        else begin
            $error("byte write outside the cycle after accepted");
            fail_count++;
        end

    a_no_overlap: assert property (@(posedge clk) disable iff (!rstn)
        !(accepted && accessed))
        else begin
            $error("accepted and accessed high together");
            fail_count++;
        end

endmodule

bind mem_access mem_properties props_i (
    .clk      (clk),
    .rstn     (rstn),
    .order    (order),
    .accepted (accepted),
    .accessed (accessed),
    .mem_we   (mem_we),
    .state    (state)
);

// ==== mem_tb.sv ====
`timescale 1ns/10ps
`include "mem_defines.svh"

module mem_tb;
    import mem_pkg::*;

    localparam int N_RANDOM = 300;
    localparam int N_WORDS  = 64;      // words in the tested window.
    localparam int LIMIT    = 16;      // cycles before a wait gives up.

    logic                 clk;
    logic                 rstn;
    mem_req_t             req;
    logic                 order;
    logic                 accepted;
    logic                 accessed;
    logic [`LEN_WORD-1:0] load_data;

    logic [31:0] lfsr;
    logic [7:0]  model_mem [0:4*N_WORDS-1];
    logic [31:0] held_load;            // load_data between accesses.
    int          n_access;
    int          n_accepted;

    tb_clock clock_i (
        .clk  (clk),
        .rstn (rstn)
    );

    mem_top dut_i (
        .clk       (clk),
        .rstn      (rstn),
        .req       (req),
        .order     (order),
        .accepted  (accepted),
        .accessed  (accessed),
        .load_data (load_data)
    );

    always @(negedge clk) begin
        if (rstn && accepted) begin
            n_accepted++;
        end
    end

    // protocol assertions in the bound checker.
    always @(negedge clk) begin
        if (dut_i.access_i.props_i.fail_count != 0) begin
            $display("a bound protocol assertion failed before time %0t", $time);
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion failure");
        end
    end

    // ------------------------------
    // helpers
    // ------------------------------

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1.
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
    endtask

    function automatic mem_op_e pick_op(input logic [2:0] k);
        case (k)
            3'd0:    return op_lb;
            3'd1:    return op_lh;
            3'd2:    return op_lw;
            3'd3:    return op_lbu;
            3'd4:    return op_lhu;
            3'd5:    return op_sb;
            3'd6:    return op_sh;
            default: return op_sw;
        endcase
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR time=%0t %s got=%h expected=%h", $time, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s at time %0t", what, $time);
        $display("SOME TESTS FAILED");
        $fatal(1, "wait limit reached");
    endtask

    // ------------------------------
    // memory model
    // ------------------------------

    function automatic logic [31:0] model_load(input mem_op_e op, input logic [7:0] a);
        logic [7:0]  base;
        logic [7:0]  b;
        logic [15:0] h;
        base = {a[7:2], 2'b00};
        b    = model_mem[a];
        h    = a[1] ? {model_mem[base+3], model_mem[base+2]}
                    : {model_mem[base+1], model_mem[base]};
        case (op)
            op_lb:   return {{24{b[7]}}, b};
            op_lbu:  return {24'h0, b};
            op_lh:   return {{16{h[15]}}, h};
            op_lhu:  return {16'h0, h};
            op_lw:   return {model_mem[base+3], model_mem[base+2],
                             model_mem[base+1], model_mem[base]};
            default: return 32'h0;
        endcase
    endfunction

    function automatic void model_store(input mem_op_e op, input logic [7:0] a,
                                        input logic [31:0] d);
        logic [7:0] lo;
        lo = (op_size(op) == sz_half) ? {a[7:1], 1'b0} : {a[7:2], 2'b00};
        case (op_size(op))
            sz_byte: model_mem[a] = d[7:0];
            sz_half: begin
                model_mem[lo]   = d[7:0];
                model_mem[lo+1] = d[15:8];
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    model_mem[lo+i] = d[8*i +: 8];
                end
            end
        endcase
    endfunction

    // one access; busy repeats order while the sequencer is working.
    task automatic run_access(input mem_op_e op, input logic [7:0] addr,
                              input logic [31:0] wdata, input int gap, input bit busy);
        logic [31:0] expect_data;
        logic [31:0] junk_addr;
        logic [31:0] junk_data;
        int          cycles;
        bit          done;

        for (int i = 0; i < gap; i++) begin
            @(negedge clk);
            check_val("accepted", accepted, 0);
            check_val("accessed", accessed, 0);
            check_val("load_data", load_data, held_load);
        end
        if (busy) begin
            draw_bits(8, junk_addr);
            draw_bits(32, junk_data);
        end
        expect_data = op_is_store(op) ? 32'h0 : model_load(op, addr);
        req.op      = op;
        req.addr    = {24'h0, addr};
        req.wdata   = wdata;
        order       = 1'b1;
        n_access++;

        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            order = busy;              // sampled in issue, must be ignored.
            check_val("accessed", accessed, 0);
            if (accepted) begin
                done = 1'b1;
            end else if (cycles > LIMIT) begin
                report_timeout("accepted");
            end
        end
        check_val("accept latency", cycles, 1);
        check_val("load_data", load_data, held_load);

        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (busy && cycles < 3) begin
                order     = 1'b1;
                req.op    = op_sw;
                req.addr  = {24'h0, junk_addr[7:0]};
                req.wdata = junk_data;
            end else begin
                order = 1'b0;
            end
            check_val("accepted", accepted, 0);
            if (accessed) begin
                done = 1'b1;
            end else if (cycles > LIMIT) begin
                report_timeout("accessed");
            end
        end
        check_val("access latency", cycles, 3);
        check_val("load_data", load_data, expect_data);
        if (op_is_store(op)) begin
            model_store(op, addr, wdata);
        end
        held_load = expect_data;
    endtask

    // ------------------------------
    // stimulus
    // ------------------------------

    initial begin
        logic [31:0] r_op;
        logic [31:0] r_addr;
        logic [31:0] r_data;
        logic [31:0] r_gap;
        logic [31:0] r_busy;
        int          waited;

        lfsr       = 32'hd9c1_f825;
        req        = '0;
        order      = 1'b0;
        held_load  = 32'h0;
        n_access   = 0;
        n_accepted = 0;

        @(negedge clk);
        waited = 0;
        while (!rstn) begin
            check_val("accepted", accepted, 0);
            check_val("accessed", accessed, 0);
            @(negedge clk);
            waited++;
            if (waited > 4 * LIMIT) begin
                report_timeout("reset release");
            end
        end
        repeat (3) begin
            @(negedge clk);
            check_val("accepted", accepted, 0);
            check_val("accessed", accessed, 0);
            check_val("load_data", load_data, 32'h0);
        end

        // fill the window so loads read known data.
        for (int w = 0; w < N_WORDS; w++) begin
            draw_bits(32, r_data);
            run_access(op_sw, {w[5:0], 2'b00}, r_data, 0, 1'b0);
        end

        // directed lane and extension cases.
        run_access(op_sw, 8'h40, 32'h80ff_7f01, 0, 1'b0);
        run_access(op_lw, 8'h40, 32'h0, 0, 1'b0);
        run_access(op_sb, 8'h41, 32'h1234_56a5, 1, 1'b1);
        run_access(op_lw, 8'h40, 32'h0, 2, 1'b0);
        run_access(op_sh, 8'h46, 32'hdead_f00f, 0, 1'b1);
        run_access(op_lw, 8'h44, 32'h0, 0, 1'b0);
        for (int a = 0; a < 4; a++) begin
            run_access(op_lb, {6'h10, a[1:0]}, 32'h0, 0, 1'b0);
            run_access(op_lbu, {6'h10, a[1:0]}, 32'h0, 1, 1'b0);
            run_access(op_lh, {6'h11, a[1:0]}, 32'h0, 0, 1'b1);
            run_access(op_lhu, {6'h11, a[1:0]}, 32'h0, 0, 1'b0);
        end

        for (int n = 0; n < N_RANDOM; n++) begin
            draw_bits(3, r_op);
            draw_bits(8, r_addr);
            draw_bits(32, r_data);
            draw_bits(2, r_gap);
            draw_bits(2, r_busy);
            run_access(pick_op(r_op[2:0]), r_addr[7:0], r_data, int'(r_gap[1:0]),
                       r_busy[1:0] == 2'b00);
        end

        repeat (3) begin
            @(negedge clk);
            check_val("accepted", accepted, 0);
            check_val("accessed", accessed, 0);
            check_val("load_data", load_data, held_load);
        end
        check_val("accepted count", n_accepted, n_access);
        if (dut_i.access_i.props_i.fail_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("%0d bound protocol assertions failed",
                     dut_i.access_i.props_i.fail_count);
            $display("SOME TESTS FAILED");
            $fatal(1, "assertion failure");
        end
    end

endmodule

// ==== all.f ====
+incdir+.
mem_pkg.sv
lsu_align.sv
mem_access.sv
data_ram.sv
mem_top.sv
tb_clock.sv
mem_properties.sv
mem_tb.sv
